//--- verilog/pma_pkg.sv
/* Shared sizes, encodings and bundles for the PMA unit.
   Region decode is fixed at 16 regions of two halves each; sizes here are not tunable. */

package pma_pkg;

  // Register file geometry
  localparam int PMA_NUM_REGS  = 16;
  localparam int PMA_REG_IDX_W = 4;

  // Bus and address widths
  localparam int PMA_ADDR_W = 32;
  localparam int PMA_DATA_W = 32;

  // Region select and half select bits of the physical address
  localparam int PMA_REGION_MSB = 31;
  localparam int PMA_REGION_LSB = 28;
  localparam int PMA_HALF_BIT   = 27;

  // Access size, ordered so a plain compare finds oversize accesses
  typedef enum logic [1:0] {
    ACC_BYTE  = 2'd0,
    ACC_HALF  = 2'd1,
    ACC_WORD  = 2'd2,
    ACC_DWORD = 2'd3
  } acc_width_t;

  // RISC-V mcause values for access faults
  typedef enum logic [3:0] {
    EXC_INSTR_ACCESS = 4'd1,
    EXC_LOAD_ACCESS  = 4'd5,
    EXC_STORE_ACCESS = 4'd7
  } exc_code_t;

  // One half-region configuration
  typedef struct packed {
    logic [10:0] reserved;
    acc_width_t  acc_width;
    logic        X;
    logic        W;
    logic        R;
  } pma_cfg_t;

  // One PMA register, bit 27 of the address picks the half
  typedef struct packed {
    pma_cfg_t cfg_1;
    pma_cfg_t cfg_0;
  } pma_reg_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [PMA_REG_IDX_W-1:0] adr;
    logic [PMA_DATA_W-1:0]    dat;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic                  ack;
    logic [PMA_DATA_W-1:0] dat;
  } wb_rsp_t;

  // Data side access from the load/store unit
  typedef struct packed {
    logic [PMA_ADDR_W-1:0] addr;
    logic                  ren;
    logic                  wen;
    acc_width_t            width;
  } pma_dacc_t;

  // Instruction fetch, always word sized
  typedef struct packed {
    logic [PMA_ADDR_W-1:0] addr;
    logic                  xen;
  } pma_iacc_t;

  // At most one flag high
  typedef struct packed {
    logic l_fault;
    logic s_fault;
    logic i_fault;
  } pma_fault_t;

  // Captured exception record
  typedef struct packed {
    logic                  valid;
    exc_code_t             cause;
    logic [PMA_ADDR_W-1:0] addr;
  } pma_exc_t;

endpackage

//--- verilog/pma_csr_file.sv
/* PMA register file behind a Wishbone classic slave; whole-register writes only.
   Ack is registered, one cycle wide; any index is accepted, no error or retry. */

`timescale 1ns/1ps

module pma_csr_file import pma_pkg::*; (
  input  logic                          CLK,
  input  logic                          nRST,
  input  wb_req_t                       wb_req,
  output wb_rsp_t                       wb_rsp,
  output pma_reg_t [PMA_NUM_REGS-1:0]   pma_regs
);

  // Attribute storage
  pma_reg_t [PMA_NUM_REGS-1:0] regs;

  // Handshake state
  logic                  ack_q;
  logic                  req;
  logic                  accept;

  // Read data returned with ack
  logic [PMA_DATA_W-1:0] rd_dat;

  // Request seen when both cyc and stb high
  assign req = wb_req.cyc & wb_req.stb;

  // Take a new request only while ack is low
  // so a held stb never gets two acks in a row
  assign accept = req & ~ack_q;

  // Ack one cycle after the request
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // Register writes land on the edge that raises ack
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '0;
    end else if (accept && wb_req.we) begin
      regs[wb_req.adr] <= pma_reg_t'(wb_req.dat);
    end
  end

  // Read capture
  // Sampled on the accepting edge, held stable through ack
  always_ff @(posedge CLK) begin
    if (accept) begin
      rd_dat <= PMA_DATA_W'(regs[wb_req.adr]);
    end
  end

  // Response bundle
  always_comb begin
    wb_rsp.ack = ack_q;
    wb_rsp.dat = rd_dat;
  end

  // Whole array goes straight to the checker
  // New values seen from the cycle after ack
  assign pma_regs = regs;

endmodule

//--- verilog/pma_checker.sv
/* Combinational PMA check of one data access and one fetch per cycle.
   Faults depend only on inputs; at most one flag is raised, load over store over fetch. */

`timescale 1ns/1ps

module pma_checker import pma_pkg::*; (
  input  pma_reg_t [PMA_NUM_REGS-1:0] pma_regs,
  input  pma_dacc_t                   dacc,
  input  pma_iacc_t                   iacc,
  output pma_fault_t                  faults
);

  // Selected register per port
  pma_reg_t reg_d;
  pma_reg_t reg_i;

  // Selected half per port
  pma_cfg_t cfg_d;
  pma_cfg_t cfg_i;

  // Oversize checks
  logic d_wide;
  logic i_wide;

  // Intermediate fault terms
  logic l_flt;
  logic s_flt;
  logic i_flt;

  // Region lookup, top nibble of the address
  assign reg_d = pma_regs[dacc.addr[PMA_REGION_MSB:PMA_REGION_LSB]];
  assign reg_i = pma_regs[iacc.addr[PMA_REGION_MSB:PMA_REGION_LSB]];

  // Half select on bit 27
  assign cfg_d = dacc.addr[PMA_HALF_BIT] ? reg_d.cfg_1 : reg_d.cfg_0;
  assign cfg_i = iacc.addr[PMA_HALF_BIT] ? reg_i.cfg_1 : reg_i.cfg_0;

  // Enum order makes this a size compare
  assign d_wide = dacc.width > cfg_d.acc_width;

  // Fetches are always a full word
  assign i_wide = ACC_WORD > cfg_i.acc_width;

  always_comb begin
    // Load: missing R or oversize read
    l_flt = dacc.ren & (~cfg_d.R | d_wide);

    // Store: missing W or oversize write
    // Masked by a load fault so a combined ren/wen access
    // never reports two flags
    s_flt = dacc.wen & (~cfg_d.W | d_wide) & ~l_flt;

    // Fetch: missing X or half too narrow for a word
    // Only reported when the data side is clean
    i_flt = iacc.xen & (~cfg_i.X | i_wide) & ~l_flt & ~s_flt;
  end

  // Output bundle
  always_comb begin
    faults.l_fault = l_flt;
    faults.s_fault = s_flt;
    faults.i_fault = i_flt;
  end

endmodule

//--- verilog/pma_fault_capture.sv
/* Holds the first PMA fault until fault_clear; later faults are dropped while held.
   A fault in the clear cycle is captured and wins; cause and addr are valid only with valid. */

`timescale 1ns/1ps

module pma_fault_capture import pma_pkg::*; (
  input  logic                  CLK,
  input  logic                  nRST,
  input  pma_fault_t            faults,
  input  logic [PMA_ADDR_W-1:0] daddr,
  input  logic [PMA_ADDR_W-1:0] iaddr,
  input  logic                  fault_clear,
  output pma_exc_t              exc
);

  // Record state
  logic                  valid_q;
  exc_code_t             cause_q;
  logic [PMA_ADDR_W-1:0] addr_q;

  // Decoded current fault
  logic                  any_fault;
  logic                  capture;
  exc_code_t             cause_d;
  logic [PMA_ADDR_W-1:0] addr_d;

  assign any_fault = faults.l_fault | faults.s_fault | faults.i_fault;

  // Slot is free when empty or being cleared this edge
  assign capture = any_fault & (~valid_q | fault_clear);

  // One-hot flag to cause code and matching address
  always_comb begin
    if (faults.l_fault) begin
      cause_d = EXC_LOAD_ACCESS;
      addr_d  = daddr;
    end else if (faults.s_fault) begin
      cause_d = EXC_STORE_ACCESS;
      addr_d  = daddr;
    end else begin
      // Fetch fault, or don't care when nothing is captured
      cause_d = EXC_INSTR_ACCESS;
      addr_d  = iaddr;
    end
  end

  // Valid flag
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (fault_clear) begin
      valid_q <= 1'b0;
    end
  end

  // Cause and address latched with valid
  always_ff @(posedge CLK) begin
    if (capture) begin
      cause_q <= cause_d;
      addr_q  <= addr_d;
    end
  end

  always_comb begin
    exc.valid = valid_q;
    exc.cause = cause_q;
    exc.addr  = addr_q;
  end

endmodule

//--- verilog/pma_unit.sv
/* PMA unit top: Wishbone-writable attribute registers, same-cycle checker, fault capture.
   All registers reset to zero, so every access faults until software programs them. */

`timescale 1ns/1ps

module pma_unit import pma_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  pma_dacc_t  dacc,
  input  pma_iacc_t  iacc,
  output pma_fault_t faults,
  input  logic       fault_clear,
  output pma_exc_t   exc
);

  // Attribute array from register file to checker
  pma_reg_t [PMA_NUM_REGS-1:0] pma_regs;

  // Register file and bus slave
  pma_csr_file csr_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .pma_regs (pma_regs)
  );

  // Same-cycle permission and width check
  pma_checker chk_i (
    .pma_regs (pma_regs),
    .dacc     (dacc),
    .iacc     (iacc),
    .faults   (faults)
  );

  // First-fault record for the trap logic
  pma_fault_capture cap_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .faults      (faults),
    .daddr       (dacc.addr),
    .iaddr       (iacc.addr),
    .fault_clear (fault_clear),
    .exc         (exc)
  );

endmodule

//--- test/pma_clock_gen.sv
/* Testbench clock and reset source: 100 ns period, nRST low for the first 3 rising edges. */

`timescale 1ns/1ps

module pma_clock_gen (
  output logic CLK,
  output logic nRST
);

  // Free-running clock, 50 ns half period
  initial begin
    CLK = 1'b0;
    forever begin
      #50 CLK = ~CLK;
    end
  end

  // Release reset just after the third rising edge
  initial begin
    nRST = 1'b0;
    repeat (3) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

//--- test/pma_unit_props.sv
/* Concurrent checks on the PMA unit outputs, bound into every pma_unit instance.
   All checks are disabled while nRST is low. */

`timescale 1ns/1ps

module pma_unit_props import pma_pkg::*; (
  input logic       CLK,
  input logic       nRST,
  input wb_rsp_t    wb_rsp,
  input pma_fault_t faults,
  input logic       fault_clear,
  input pma_exc_t   exc
);

  // Ack is a single-cycle pulse
  ack_pulse: assert property (
    @(posedge CLK) disable iff (!nRST)
    wb_rsp.ack |=> !wb_rsp.ack
  ) else $error("Wishbone ack stayed high for two cycles");

  // Load, store and fetch flags are mutually exclusive
  one_fault: assert property (
    @(posedge CLK) disable iff (!nRST)
    $onehot0({faults.l_fault, faults.s_fault, faults.i_fault})
  ) else $error("More than one fault flag high");

  // Captured record only drops on a clear
  exc_held: assert property (
    @(posedge CLK) disable iff (!nRST)
    (exc.valid && !fault_clear) |=> exc.valid
  ) else $error("exc.valid dropped without fault_clear");

endmodule

bind pma_unit pma_unit_props props_i (
  .CLK         (CLK),
  .nRST        (nRST),
  .wb_rsp      (wb_rsp),
  .faults      (faults),
  .fault_clear (fault_clear),
  .exc         (exc)
);

//--- test/pma_unit_tb.sv
/* Random testbench for the PMA unit, checked against a behavioral model of the rules.
   Fixed seed; inputs change 1 ns after the rising edge, faults sampled mid-cycle. */

`timescale 1ns/1ps

module pma_unit_tb import pma_pkg::*; ();

  localparam int unsigned SEED        = 32'h1402_f4a6;
  localparam int          ACK_TIMEOUT = 20;
  localparam int          RST_TIMEOUT = 20;
  localparam int          SAMPLE_DLY  = 40;

  logic       CLK;
  logic       nRST;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  pma_dacc_t  dacc;
  pma_iacc_t  iacc;
  pma_fault_t faults;
  logic       fault_clear;
  pma_exc_t   exc;

  // Model of registers and capture record
  logic [PMA_DATA_W-1:0] model_regs [PMA_NUM_REGS];
  logic                  model_valid;
  exc_code_t             model_cause;
  logic [PMA_ADDR_W-1:0] model_addr;

  int unsigned check_count;
  int unsigned error_count;
  int unsigned timeout_count;

  pma_clock_gen clk_i (
    .CLK  (CLK),
    .nRST (nRST)
  );

  pma_unit dut_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .dacc        (dacc),
    .iacc        (iacc),
    .faults      (faults),
    .fault_clear (fault_clear),
    .exc         (exc)
  );

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error @ %0t: %s got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  // Half-region config as the model sees it
  function automatic pma_cfg_t model_cfg(input logic [PMA_ADDR_W-1:0] addr);
    pma_reg_t r;
    r = pma_reg_t'(model_regs[addr[PMA_REGION_MSB:PMA_REGION_LSB]]);
    if (addr[PMA_HALF_BIT]) begin
      return r.cfg_1;
    end
    return r.cfg_0;
  endfunction

  // Priority load over store over fetch
  // Oversize data accesses raise the data faults
  function automatic pma_fault_t model_faults(input pma_dacc_t d, input pma_iacc_t i);
    pma_cfg_t   cd;
    pma_cfg_t   ci;
    pma_fault_t f;
    logic       too_wide;
    cd       = model_cfg(d.addr);
    ci       = model_cfg(i.addr);
    too_wide = d.width > cd.acc_width;
    f        = '0;
    if (d.ren && (!cd.R || too_wide)) begin
      f.l_fault = 1'b1;
    end else if (d.wen && (!cd.W || too_wide)) begin
      f.s_fault = 1'b1;
    end else if (i.xen && (!ci.X || ci.acc_width < ACC_WORD)) begin
      f.i_fault = 1'b1;
    end
    return f;
  endfunction

  // One clock edge of the capture rules
  function automatic void model_capture(input pma_fault_t f, input logic clr,
                                        input logic [PMA_ADDR_W-1:0] daddr,
                                        input logic [PMA_ADDR_W-1:0] iaddr);
    if ((f != '0) && (!model_valid || clr)) begin
      model_valid = 1'b1;
      if (f.l_fault) begin
        model_cause = EXC_LOAD_ACCESS;
        model_addr  = daddr;
      end else if (f.s_fault) begin
        model_cause = EXC_STORE_ACCESS;
        model_addr  = daddr;
      end else begin
        model_cause = EXC_INSTR_ACCESS;
        model_addr  = iaddr;
      end
    end else if (clr) begin
      model_valid = 1'b0;
    end
  endfunction

  // Cause and addr only meaningful while valid
  task automatic check_exc();
    check_value(32'(exc.valid), 32'(model_valid), "exc.valid");
    if (model_valid) begin
      check_value(32'(exc.cause), 32'(model_cause), "exc.cause");
      check_value(exc.addr, model_addr, "exc.addr");
    end
  endtask

  // One Wishbone classic cycle returning read data sampled with ack
  // Back to back when the previous cycle left stb high
  task automatic wb_transfer(input logic we, input logic [PMA_REG_IDX_W-1:0] idx,
                             input logic [PMA_DATA_W-1:0] wdata,
                             output logic [PMA_DATA_W-1:0] rdata);
    int cycles;
    if (!wb_req.stb) begin
      @(posedge CLK);
      #1;
    end
    // Access ports idle while the bus is busy
    dacc        = '0;
    iacc        = '0;
    fault_clear = 1'b0;
    wb_req.cyc  = 1'b1;
    wb_req.stb  = 1'b1;
    wb_req.we   = we;
    wb_req.adr  = idx;
    wb_req.dat  = wdata;
    cycles = 0;
    do begin
      @(posedge CLK);
      #1;
      cycles++;
    end while (!wb_rsp.ack && cycles < ACK_TIMEOUT);
    rdata = wb_rsp.dat;
    if (!wb_rsp.ack) begin
      timeout_count++;
      $display("Timeout: no Wishbone ack for register %0d within %0d cycles", idx, ACK_TIMEOUT);
    end else if (we) begin
      model_regs[idx] = wdata;
    end
  endtask

  task automatic wb_write(input logic [PMA_REG_IDX_W-1:0] idx, input logic [PMA_DATA_W-1:0] data);
    logic [PMA_DATA_W-1:0] unused_rd;
    wb_transfer(1'b1, idx, data, unused_rd);
  endtask

  task automatic wb_read_check(input logic [PMA_REG_IDX_W-1:0] idx);
    logic [PMA_DATA_W-1:0] rd;
    wb_transfer(1'b0, idx, '0, rd);
    check_value(rd, model_regs[idx], $sformatf("read of PMA register %0d", idx));
  endtask

  // Random attributes in every register
  task automatic program_random_config();
    for (int i = 0; i < PMA_NUM_REGS; i++) begin
      wb_write(4'(i), $urandom);
    end
  endtask

  // One access cycle with flags checked mid-cycle before the model steps
  task automatic apply_access(input pma_dacc_t d, input pma_iacc_t i, input logic clr);
    pma_fault_t expected;
    @(posedge CLK);
    #1;
    check_exc();
    // Bus released while the access ports run
    wb_req.cyc  = 1'b0;
    wb_req.stb  = 1'b0;
    wb_req.we   = 1'b0;
    dacc        = d;
    iacc        = i;
    fault_clear = clr;
    #SAMPLE_DLY;
    expected = model_faults(d, i);
    check_value(32'(faults), 32'(expected), "fault flags {l,s,i}");
    model_capture(expected, clr, d.addr, i.addr);
  endtask

  // Low two bits pick read, write, both or none
  function automatic pma_dacc_t random_dacc();
    pma_dacc_t   d;
    logic [31:0] r;
    r       = $urandom;
    d.addr  = $urandom;
    d.ren   = ~r[0];
    d.wen   = r[0] ^ r[1];
    d.width = acc_width_t'(r[3:2]);
    return d;
  endfunction

  function automatic pma_iacc_t random_iacc(input logic allow_xen);
    pma_iacc_t   i;
    logic [31:0] r;
    r      = $urandom;
    i.addr = $urandom;
    i.xen  = allow_xen & (r[1:0] != 2'b00);
    return i;
  endfunction

  initial begin
    int          cycles;
    logic [31:0] r;
    wb_req        = '0;
    dacc          = '0;
    iacc          = '0;
    fault_clear   = 1'b0;
    model_valid   = 1'b0;
    model_cause   = EXC_INSTR_ACCESS;
    model_addr    = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    for (int i = 0; i < PMA_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(SEED));

    cycles = 0;
    while (!nRST && cycles < RST_TIMEOUT) begin
      @(posedge CLK);
      cycles++;
    end
    if (!nRST) begin
      timeout_count++;
      $display("Timeout: reset was never released");
    end

    // Registers reset to zero so every enabled access faults
    for (int i = 0; i < PMA_NUM_REGS; i++) begin
      wb_read_check(4'(i));
    end
    for (int n = 0; n < 30; n++) begin
      apply_access(random_dacc(), random_iacc(1'b1), 1'b0);
    end

    // Random writes followed by a read of every register
    for (int n = 0; n < 24; n++) begin
      r = $urandom;
      wb_write(r[3:0], $urandom);
    end
    for (int i = 0; i < PMA_NUM_REGS; i++) begin
      wb_read_check(4'(i));
    end

    // Data side only with a fresh config per round
    for (int round = 0; round < 4; round++) begin
      program_random_config();
      for (int n = 0; n < 60; n++) begin
        r = $urandom;
        apply_access(random_dacc(), random_iacc(1'b0), r[2:0] == 3'b000);
      end
    end

    // Fetches alongside data accesses
    for (int round = 0; round < 4; round++) begin
      program_random_config();
      for (int n = 0; n < 60; n++) begin
        r = $urandom;
        apply_access(random_dacc(), random_iacc(1'b1), r[2:0] == 3'b000);
      end
    end

    // Frequent clears to hit clear against a new fault
    program_random_config();
    for (int n = 0; n < 150; n++) begin
      r = $urandom;
      apply_access(random_dacc(), random_iacc(1'b1), r[9:8] == 2'b00);
    end
    apply_access('0, '0, 1'b0);
    apply_access('0, '0, 1'b0);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- pma_unit.f
verilog/pma_pkg.sv
verilog/pma_csr_file.sv
verilog/pma_checker.sv
verilog/pma_fault_capture.sv
verilog/pma_unit.sv
test/pma_clock_gen.sv
test/pma_unit_props.sv
test/pma_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PMA unit testbench with Verilator.
# Exit status is zero only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module pma_unit_tb -Mdir obj_dir -f pma_unit.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vpma_unit_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
